/* files.f */
hdl/tgen_pkg.sv
hdl/req_timer.sv
hdl/rid_pool.sv
hdl/pkt_sched.sv
hdl/pkt_framer.sv
hdl/tgen_top.sv
testbench/tgen_tb.sv

/* hdl/pkt_framer.sv */
//========================================
// output word builder
// address window, read/write data counters
//========================================
module pkt_framer (
  input  logic                 clk,
  input  logic                 rst,
  input  tgen_pkg::tgen_beat_s i_beat,
  output logic                 o_stb,
  output logic                 o_sof,
  output tgen_pkg::tgen_word_u o_data
);

  tgen_pkg::addr_t     addr;      // next packet address
  logic [63:0]         rd_cnt;    // reads sent so far
  logic [63:0]         wr_cnt;    // writes sent so far
  tgen_pkg::tgen_word_u nxt_word;

  //========================================
  // address and data counters
  //========================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      addr   <= tgen_pkg::ADDR_BASE;
      rd_cnt <= '0;
      wr_cnt <= '0;
    end
    else if (i_beat.hdr)
    begin
      // step by 8, wrap after the top
      if (addr >= tgen_pkg::ADDR_TOP)
        addr <= tgen_pkg::ADDR_BASE;
      else
        addr <= addr + tgen_pkg::ADDR_STEP;
      if (i_beat.is_wr)
        wr_cnt <= wr_cnt + 1'b1;
      else
        rd_cnt <= rd_cnt + 1'b1;
    end
  end

  //========================================
  // word build
  //========================================
  always_comb
  begin
    nxt_word = '0;
    if (i_beat.hdr)
    begin
      nxt_word.hdr.tag  = tgen_pkg::HDR_TAG;
      nxt_word.hdr.pp   = i_beat.pp;
      nxt_word.hdr.rsvd = '0;
      nxt_word.hdr.sid  = {i_beat.is_wr ? tgen_pkg::SID_WR : tgen_pkg::SID_RD,
                           i_beat.id[tgen_pkg::ID_W-1]};     // id msb
      nxt_word.hdr.rid  = i_beat.id[tgen_pkg::ID_W-2:0];
      nxt_word.hdr.len  = i_beat.is_wr;                     // long packet
      nxt_word.hdr.addr = addr[tgen_pkg::ADDR_W-1:3];
      nxt_word.hdr.mode = i_beat.is_wr ? tgen_pkg::MODE_WR : tgen_pkg::MODE_RD;
    end
    else if (i_beat.dat)
    begin
      // counter already bumped by the header
      nxt_word.dat.mark    = tgen_pkg::DAT_MARK;
      nxt_word.dat.payload = i_beat.is_wr ? wr_cnt : rd_cnt;
    end
  end

  // output strobes
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      o_stb <= 1'b0;
      o_sof <= 1'b0;
    end
    else
    begin
      o_stb <= i_beat.hdr | i_beat.dat;  // high across the packet
      o_sof <= i_beat.hdr;
    end
  end

  always_ff @(posedge clk)
  begin
    o_data <= nxt_word;
  end

endmodule

/* hdl/pkt_sched.sv */
//========================================
// source selection and packet sequencing
// priority per kind, read/write alternation
// header and data beat fsm
//========================================
module pkt_sched (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic [tgen_pkg::N_SRC-1:0]                  i_pending,
  input  logic [tgen_pkg::N_SRC-1:0]                  i_avail,
  input  tgen_pkg::id_t [tgen_pkg::N_SRC-1:0]         i_head_id,
  input  logic [1:0]                                  i_rdy,      // bit0 reads, bit1 writes
  output logic [tgen_pkg::N_SRC-1:0]                  o_grant,
  output tgen_pkg::tgen_beat_s                        o_beat
);

  logic [tgen_pkg::N_SRC-1:0] elig;
  logic [tgen_pkg::N_PP-1:0]  rd_elig;
  logic [tgen_pkg::N_PP-1:0]  wr_elig;
  logic                       rd_any;
  logic                       wr_any;
  logic                       pick_wr;    // write wins this grant
  logic [1:0]                 sel_pp;
  tgen_pkg::src_t             sel_src;
  logic                       idle;
  logic                       go;         // grant this cycle
  tgen_pkg::beat_cnt_t        dat_left;   // data beats still to send
  logic                       cur_wr;     // kind of packet in flight
  logic                       prefer_wr;  // alternation flag

  // highest set bit wins
  function automatic logic [1:0] hi_pp(input logic [tgen_pkg::N_PP-1:0] v);
    logic [1:0] p;
    p = 2'd0;
    for (int k = 0; k < tgen_pkg::N_PP; k++)
      if (v[k])
        p = 2'(k);
    return p;
  endfunction

  //========================================
  // eligibility
  //========================================
  // ready of a kind only matters at the grant
  assign elig = i_pending & i_avail &
                {{tgen_pkg::N_PP{i_rdy[1]}}, {tgen_pkg::N_PP{i_rdy[0]}}};
  assign rd_elig = elig[tgen_pkg::N_PP-1:0];
  assign wr_elig = elig[tgen_pkg::N_SRC-1:tgen_pkg::N_PP];
  assign rd_any  = |rd_elig;
  assign wr_any  = |wr_elig;

  // other kind goes when only one is eligible
  assign pick_wr = wr_any && (prefer_wr || !rd_any);
  assign sel_pp  = pick_wr ? hi_pp(wr_elig) : hi_pp(rd_elig);
  assign sel_src = {pick_wr, sel_pp};

  // free once the last data beat is out, so packets run back to back
  assign idle = (dat_left == '0);
  assign go   = idle && (rd_any || wr_any);

  always_comb
  begin
    o_grant = '0;
    if (go)
      o_grant[sel_src] = 1'b1;  // one timer and one pool
  end

  //========================================
  // beat fsm
  //========================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      dat_left  <= '0;
      cur_wr    <= 1'b0;
      prefer_wr <= 1'b0;  // reads first
    end
    else if (go)
    begin
      dat_left  <= pick_wr ? tgen_pkg::beat_cnt_t'(tgen_pkg::WR_BEATS)
                           : tgen_pkg::beat_cnt_t'(1);
      cur_wr    <= pick_wr;
      prefer_wr <= !pick_wr;  // swap preference
    end
    else if (!idle)
      dat_left <= dat_left - 1'b1;
  end

  // command to the framer, registered there
  always_comb
  begin
    o_beat = '0;
    if (go)
    begin
      o_beat.hdr   = 1'b1;
      o_beat.is_wr = pick_wr;
      o_beat.pp    = sel_pp;
      o_beat.id    = i_head_id[sel_src];  // popped the same cycle
    end
    else if (!idle)
    begin
      o_beat.dat   = 1'b1;
      o_beat.is_wr = cur_wr;
    end
  end

endmodule

/* hdl/req_timer.sv */
//========================================
// per-source request generator
// period counter and pending count
//========================================
module req_timer #(
  parameter int PERIOD = 40  // cycles between requests
) (
  input  logic clk,
  input  logic rst,
  input  logic i_grant,      // one request taken
  output logic o_pending
);

  tgen_pkg::per_t per_cnt;   // counts down to zero
  tgen_pkg::cnt_t pend_cnt;  // 0..32 requests waiting
  logic           at_zero;
  logic           full;
  logic           tick;

  assign at_zero = (per_cnt == '0);
  assign full    = (pend_cnt == tgen_pkg::POOL_DEPTH);
  // a grant in the same cycle frees the slot
  assign tick    = at_zero && (!full || i_grant);

  // period counter, parks at zero while full
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      per_cnt <= tgen_pkg::per_t'(PERIOD - 1);
    else if (tick)
      per_cnt <= tgen_pkg::per_t'(PERIOD - 1);  // reload
    else if (!at_zero)
      per_cnt <= per_cnt - 1'b1;
  end

  // pending requests
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      pend_cnt <= '0;
    else
    begin
      case ({tick, i_grant})
        2'b10:   pend_cnt <= pend_cnt + 1'b1;
        2'b01:   pend_cnt <= pend_cnt - 1'b1;
        default: pend_cnt <= pend_cnt;  // none or both
      endcase
    end
  end

  assign o_pending = (pend_cnt != '0);

endmodule

/* hdl/rid_pool.sv */
//========================================
// per-source pool of request ids
// 32 deep circular fifo, self filling
//========================================
module rid_pool (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_ret,     // id comes back
  input  logic [tgen_pkg::ID_W-1:0] i_ret_id,
  input  logic                      i_pop,     // head id leaves
  output logic                      o_avail,
  output logic [tgen_pkg::ID_W-1:0] o_id
);

  tgen_pkg::id_t  mem [tgen_pkg::POOL_DEPTH];
  tgen_pkg::id_t  rd_ptr;
  tgen_pkg::id_t  wr_ptr;     // wraps at 32 by width
  tgen_pkg::cnt_t used;       // ids held
  tgen_pkg::cnt_t fill_cnt;   // start-up fill 0..32
  logic           fill_done;
  logic           push;
  logic           pop;
  tgen_pkg::id_t  push_id;

  assign fill_done = (fill_cnt == tgen_pkg::POOL_DEPTH);

  //========================================
  // push source mux
  //========================================
  // fill writes 0..31, then returns take over
  assign push    = fill_done ? i_ret : 1'b1;
  assign push_id = fill_done ? i_ret_id : fill_cnt[tgen_pkg::ID_W-1:0];
  assign pop     = i_pop && o_avail;  // never pop an empty pool

  // storage
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_id;
  end

  //========================================
  // pointers and occupancy
  //========================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      rd_ptr   <= '0;
      wr_ptr   <= '0;
      used     <= '0;
      fill_cnt <= '0;
    end
    else
    begin
      if (!fill_done)
        fill_cnt <= fill_cnt + 1'b1;
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;  // both honored, count unchanged
      endcase
    end
  end

  // empty until the fill is over
  assign o_avail = fill_done && (used != '0);
  assign o_id    = mem[rd_ptr];  // head of the fifo

endmodule

/* hdl/tgen_pkg.sv */
//========================================
// shared constants of the traffic generator
// packet header struct, data word struct
// bus word union, scheduler beat struct
//========================================
package tgen_pkg;

  //========================================
  // sizes
  //========================================
  localparam int N_PP       = 4;   // priority levels
  localparam int N_SRC      = 8;   // 0..3 reads, 4..7 writes
  localparam int SRC_W      = $clog2(N_SRC);
  localparam int ID_W       = 5;   // request id width
  localparam int POOL_DEPTH = 32;  // ids per pool, also max pending
  localparam int CNT_W      = $clog2(POOL_DEPTH) + 1;  // 0..32
  localparam int PER_W      = 7;   // enough for the longest period
  localparam int WR_BEATS   = 8;   // data words of a write
  localparam int BEAT_CNT_W = $clog2(WR_BEATS + 1);
  localparam int ADDR_W     = 39;  // byte address

  // periods in cycles, indexed by source
  localparam int SRC_PERIOD [N_SRC] = '{40, 33, 27, 21, 90, 75, 61, 50};

  //========================================
  // address window and field codes
  //========================================
  localparam logic [ADDR_W-1:0] ADDR_BASE = 39'h00_8000_0000;
  localparam logic [ADDR_W-1:0] ADDR_TOP  = ADDR_BASE + 39'd248;  // small window, wraps often
  localparam logic [ADDR_W-1:0] ADDR_STEP = 39'd8;

  localparam logic [1:0] HDR_TAG  = 2'b10;
  localparam logic [2:0] MODE_RD  = 3'd1;
  localparam logic [2:0] MODE_WR  = 3'd2;
  localparam logic [2:0] SID_RD   = 3'd4;  // upper sid bits
  localparam logic [2:0] SID_WR   = 3'd6;
  localparam logic [7:0] DAT_MARK = 8'hFF;

  typedef logic [ID_W-1:0]       id_t;
  typedef logic [SRC_W-1:0]      src_t;
  typedef logic [CNT_W-1:0]      cnt_t;
  typedef logic [PER_W-1:0]      per_t;
  typedef logic [BEAT_CNT_W-1:0] beat_cnt_t;
  typedef logic [ADDR_W-1:0]     addr_t;

  //========================================
  // bus words
  //========================================
  typedef struct packed {
    logic [1:0]  tag;   // always 10
    logic [1:0]  pp;
    logic [19:0] rsvd;
    logic [3:0]  sid;   // low bit is id msb
    logic [3:0]  rid;   // id low bits
    logic        len;   // 1 for long (write) packets
    logic [35:0] addr;  // byte address >> 3
    logic [2:0]  mode;
  } tgen_hdr_s;

  typedef struct packed {
    logic [7:0]  mark;
    logic [63:0] payload;
  } tgen_dat_s;

  // header when sof is set, data otherwise
  typedef union packed {
    tgen_hdr_s hdr;
    tgen_dat_s dat;
  } tgen_word_u;

  // one scheduler command per cycle
  typedef struct packed {
    logic            hdr;    // header beat, carries a grant
    logic            dat;    // data beat
    logic            is_wr;
    logic [1:0]      pp;
    logic [ID_W-1:0] id;
  } tgen_beat_s;

endpackage

/* hdl/tgen_top.sv */
//========================================
// traffic generator top
// timers, id pools, response decode,
// scheduler and framer
//========================================
module tgen_top (
  input  logic                 clk,
  input  logic                 rst,
  // response bus
  input  logic                 i_stb,
  input  logic                 i_sof,
  input  tgen_pkg::tgen_word_u i_data,
  // request bus
  output logic                 o_stb,
  output logic                 o_sof,
  output tgen_pkg::tgen_word_u o_data,
  input  logic [1:0]           i_rdy   // bit0 reads, bit1 writes
);

  logic [tgen_pkg::N_SRC-1:0]          pending;
  logic [tgen_pkg::N_SRC-1:0]          avail;
  tgen_pkg::id_t [tgen_pkg::N_SRC-1:0] head_id;
  logic [tgen_pkg::N_SRC-1:0]          grant;
  logic [tgen_pkg::N_SRC-1:0]          ret_stb;
  tgen_pkg::tgen_beat_s                beat;
  logic                                rsp_hit;
  logic                                rsp_wr;
  tgen_pkg::src_t                      rsp_src;
  tgen_pkg::id_t                       rsp_id;

  //========================================
  // response header decode
  //========================================
  assign rsp_hit = i_stb && i_sof;  // only headers count
  assign rsp_wr  = (i_data.hdr.mode == tgen_pkg::MODE_WR);  // other modes are reads
  assign rsp_src = {rsp_wr, i_data.hdr.pp};
  assign rsp_id  = {i_data.hdr.sid[0], i_data.hdr.rid};

  //========================================
  // per-source timer and pool
  //========================================
  for (genvar g = 0; g < tgen_pkg::N_SRC; g++)
  begin : g_src
    assign ret_stb[g] = rsp_hit && (rsp_src == g);

    req_timer #(
      .PERIOD (tgen_pkg::SRC_PERIOD[g])
    ) u_timer (
      .clk       (clk),
      .rst       (rst),
      .i_grant   (grant[g]),
      .o_pending (pending[g])
    );

    rid_pool u_pool (
      .clk      (clk),
      .rst      (rst),
      .i_ret    (ret_stb[g]),
      .i_ret_id (rsp_id),
      .i_pop    (grant[g]),
      .o_avail  (avail[g]),
      .o_id     (head_id[g])
    );
  end

  pkt_sched u_sched (
    .clk       (clk),
    .rst       (rst),
    .i_pending (pending),
    .i_avail   (avail),
    .i_head_id (head_id),
    .i_rdy     (i_rdy),
    .o_grant   (grant),
    .o_beat    (beat)
  );

  pkt_framer u_framer (
    .clk    (clk),
    .rst    (rst),
    .i_beat (beat),
    .o_stb  (o_stb),
    .o_sof  (o_sof),
    .o_data (o_data)
  );

endmodule

/* testbench/tgen_tb.sv */
//========================================
// testbench of the traffic generator
// phase table, response injection,
// packet monitor with reference model
//========================================
module tgen_tb;

  typedef struct packed {
    logic [1:0] rdy;     // o_rdy during the phase
    int         len;     // cycles
    logic       ret;     // answer outstanding ids
    int         rd_min;
    int         rd_max;
    int         wr_min;
    int         wr_max;
  } phase_s;

  localparam int N_PH = 4;

  logic                 clk;
  logic                 rst;
  logic                 i_stb;
  logic                 i_sof;
  tgen_pkg::tgen_word_u i_data;
  logic [1:0]           i_rdy;
  logic                 o_stb;
  logic                 o_sof;
  tgen_pkg::tgen_word_u o_data;

  phase_s      phases [N_PH];
  int          rd_seen [N_PH];   // read headers per phase
  int          wr_seen [N_PH];
  int          cur_ph;           // phase whose o_rdy was used at the grant
  int          run_cyc;
  int          cyc_cnt;
  int          tmo_limit;
  logic [38:0] exp_addr;         // model byte address
  logic [63:0] exp_rd;
  logic [63:0] exp_wr;
  logic [63:0] exp_pay;          // payload of the packet in flight
  int          beats_left;       // data words still owed
  logic [4:0]  exp_ids [8][32];  // model id pools, circular
  int          ids_hd [8];
  int          ids_tl [8];
  logic [7:0]  outst [$];        // {src, id} not yet answered
  int          seed;

  tgen_top uut (
    .clk    (clk),
    .rst    (rst),
    .i_stb  (i_stb),
    .i_sof  (i_sof),
    .i_data (i_data),
    .o_stb  (o_stb),
    .o_sof  (o_sof),
    .o_data (o_data),
    .i_rdy  (i_rdy)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #5 clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  //========================================
  // packet monitor and reference model
  //========================================
  task automatic observe_outputs();
    logic       is_wr;
    logic [2:0] src;
    logic [4:0] id;
    is_wr = (o_data.hdr.mode == 3'd2);
    src   = {is_wr, o_data.hdr.pp};
    id    = {o_data.hdr.sid[0], o_data.hdr.rid};  // sid lsb is id msb
    if (o_stb && o_sof)
    begin
      if (beats_left != 0)
        stop_on_error("new header before the previous packet was complete");
      if (!i_rdy[is_wr])
        stop_on_error("header of a kind whose ready bit was low at the grant");
      check_val("o_data.hdr.tag", o_data.hdr.tag, 2'b10);
      check_val("o_data.hdr.mode", o_data.hdr.mode, is_wr ? 3'd2 : 3'd1);
      check_val("o_data.hdr.len", o_data.hdr.len, is_wr);
      check_val("o_data.hdr.sid[3:1]", o_data.hdr.sid[3:1], is_wr ? 3'd6 : 3'd4);
      check_val("o_data.hdr.rsvd", o_data.hdr.rsvd, 0);
      check_val("o_data.hdr.addr", o_data.hdr.addr, exp_addr[38:3]);
      if (ids_tl[src] == ids_hd[src])
        stop_on_error($sformatf("source %0d sent a packet with its id pool empty", src));
      check_val("o_data.hdr id", id, exp_ids[src][ids_hd[src] % 32]);
      ids_hd[src]++;
      outst.push_back({src, id});
      if (exp_addr == tgen_pkg::ADDR_TOP)
        exp_addr = tgen_pkg::ADDR_BASE;  // window wraps
      else
        exp_addr = exp_addr + 39'd8;
      if (is_wr)
      begin
        exp_wr++;
        exp_pay    = exp_wr;
        beats_left = 8;
        wr_seen[cur_ph]++;
      end
      else
      begin
        exp_rd++;
        exp_pay    = exp_rd;
        beats_left = 1;
        rd_seen[cur_ph]++;
      end
    end
    else if (o_stb)
    begin
      if (beats_left == 0)
        stop_on_error("data word outside of a packet");
      check_val("o_data.dat.mark", o_data.dat.mark, 8'hFF);
      check_val("o_data.dat.payload", o_data.dat.payload, exp_pay);
      beats_left--;
    end
    else if (beats_left != 0)
      stop_on_error("o_stb dropped in the middle of a packet");
  endtask

  // answer one random outstanding id
  task automatic drive_response(input logic en);
    int         k;
    logic [7:0] item;
    i_stb  = 1'b0;
    i_sof  = 1'b0;
    i_data = '0;
    if (en && outst.size() > 0)
    begin
      k    = $urandom % outst.size();
      item = outst[k];
      outst.delete(k);
      i_stb           = 1'b1;
      i_sof           = 1'b1;
      i_data.hdr.tag  = 2'b10;
      i_data.hdr.pp   = item[6:5];
      i_data.hdr.mode = item[7] ? tgen_pkg::MODE_WR : tgen_pkg::MODE_RD;
      i_data.hdr.sid  = {3'd0, item[4]};
      i_data.hdr.rid  = item[3:0];
      exp_ids[item[7:5]][ids_tl[item[7:5]] % 32] = item[4:0];  // back at the tail
      ids_tl[item[7:5]]++;
    end
  endtask

  // hang guard
  always @(posedge clk)
  begin
    cyc_cnt++;
    if (cyc_cnt > tmo_limit)
      stop_on_error("run timed out before all phases ended");
  end

  //========================================
  // main sequence
  //========================================
  initial
  begin
    seed      = $urandom(32'h22ac);
    phases[0] = '{2'b11, 800, 1'b0, 90, 110, 36, 50};    // pools drain, no answers
    phases[1] = '{2'b01, 300, 1'b0, 12, 26, 0, 0};       // writes held off
    phases[2] = '{2'b10, 400, 1'b0, 0, 0, 35, 46};       // reads held off
    phases[3] = '{2'b11, 1200, 1'b1, 90, 300, 40, 140};  // ids recycled
    tmo_limit = 200;
    foreach (phases[p])
      tmo_limit += phases[p].len;
    cyc_cnt    = 0;
    rst        = 1'b1;
    i_stb      = 1'b0;
    i_sof      = 1'b0;
    i_data     = '0;
    i_rdy      = phases[0].rdy;
    exp_addr   = tgen_pkg::ADDR_BASE;
    exp_rd     = '0;
    exp_wr     = '0;
    exp_pay    = '0;
    beats_left = 0;
    cur_ph     = 0;
    for (int s = 0; s < 8; s++)
    begin
      for (int k = 0; k < 32; k++)
        exp_ids[s][k] = 5'(k);  // fill order 0..31
      ids_hd[s] = 0;
      ids_tl[s] = 32;
    end
    foreach (phases[p])
    begin
      rd_seen[p] = 0;
      wr_seen[p] = 0;
    end
    repeat (10)
    begin
      @(negedge clk);
      check_val("o_stb", o_stb, 0);
      check_val("o_sof", o_sof, 0);
    end
    rst     = 1'b0;
    run_cyc = 0;
    for (int p = 0; p < N_PH; p++)
    begin
      for (int c = 0; c < phases[p].len; c++)
      begin
        @(negedge clk);
        if (run_cyc < 32)
        begin
          check_val("o_stb", o_stb, 0);  // pools still filling
          check_val("o_sof", o_sof, 0);
        end
        observe_outputs();
        cur_ph = p;
        i_rdy  = phases[p].rdy;
        drive_response(phases[p].ret);
        run_cyc++;
      end
    end
    @(negedge clk);
    observe_outputs();  // last grant of the final phase
    foreach (phases[p])
    begin
      if (rd_seen[p] < phases[p].rd_min || rd_seen[p] > phases[p].rd_max)
        stop_on_error($sformatf("phase %0d sent %0d reads, outside %0d to %0d",
                                p, rd_seen[p], phases[p].rd_min, phases[p].rd_max));
      if (wr_seen[p] < phases[p].wr_min || wr_seen[p] > phases[p].wr_max)
        stop_on_error($sformatf("phase %0d sent %0d writes, outside %0d to %0d",
                                p, wr_seen[p], phases[p].wr_min, phases[p].wr_max));
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule
